// ==== verilog/ex_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types of the reduced execute stage
// Lanes are fixed at four bytes; the vector mode picks word, half or byte
// Enum encodings follow the core decoder and must not be reordered
////////////////////////////////////////////////////////////

package ex_pkg;

  // Datapath sizes
  localparam int xlen       = 32;
  localparam int lane_w     = 8;
  localparam int n_lanes    = xlen / lane_w;
  localparam int reg_addr_w = 6;
  localparam int alu_op_w   = 4;

  // ALU operators, arithmetic first and compares last
  typedef enum logic [alu_op_w-1:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_eq,
    alu_ne,
    alu_lts,
    alu_ltu,
    alu_ges,
    alu_geu
  } alu_op_e;

  // Element size of packed SIMD operations
  typedef enum logic [1:0] {
    vec_word = 2'b00,
    vec_half = 2'b10,
    vec_byte = 2'b11
  } vec_mode_e;

  // Job of one byte lane
  typedef enum logic [1:0] {
    lf_sum,
    lf_and,
    lf_or,
    lf_xor
  } lane_func_e;

  // One operand word seen as a word, as halves or as bytes
  typedef union packed {
    logic [xlen-1:0]                  word;
    logic [1:0][2*lane_w-1:0]         half;
    logic [n_lanes-1:0][lane_w-1:0]   bytes;
  } simd_word_u;

  // Per lane inputs, b is already inverted for subtract and compare
  typedef struct packed {
    logic [lane_w-1:0] a;
    logic [lane_w-1:0] b;
    logic              chain;
    logic              carry_seed;
    lane_func_e        func;
  } lane_in_t;

  // Per lane outputs with the original operand sign bits
  typedef struct packed {
    logic [lane_w-1:0] result;
    logic              carry_o;
    logic              a_msb;
    logic              b_msb;
  } lane_out_t;

  typedef struct packed {
    logic            en;
    alu_op_e         operator;
    vec_mode_e       vec_mode;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] operand_c;
  } alu_req_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] alu_waddr;
    logic                  alu_we;
    logic [reg_addr_w-1:0] lsu_waddr;
    logic                  lsu_we;
  } wb_ctrl_t;

  // Register file write port
  typedef struct packed {
    logic [reg_addr_w-1:0] waddr;
    logic                  we;
    logic [xlen-1:0]       wdata;
  } wr_port_t;

endpackage

// ==== verilog/alu_lane.sv ====
////////////////////////////////////////////////////////////
// One byte lane: adder or bitwise logic
// Carry out is the adder carry whatever the function
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_lane (
  input  ex_pkg::lane_in_t  lane_i,
  input  logic              carry_i,
  output ex_pkg::lane_out_t lane_o
);

  import ex_pkg::*;

  logic              cin;
  logic [lane_w:0]   sum;
  logic              b_inverted;

  // Chained lanes continue the element, others start fresh
  assign cin = lane_i.chain ? carry_i : lane_i.carry_seed;

  assign sum = {1'b0, lane_i.a} + {1'b0, lane_i.b} + {{lane_w{1'b0}}, cin};

  // Only subtract and compares arrive with b inverted
  assign b_inverted = (lane_i.func == lf_sum) && lane_i.carry_seed;

  always_comb begin
    unique case (lane_i.func)
      lf_sum:  lane_o.result = sum[lane_w-1:0];
      lf_and:  lane_o.result = lane_i.a & lane_i.b;
      lf_or:   lane_o.result = lane_i.a | lane_i.b;
      default: lane_o.result = lane_i.a ^ lane_i.b;
    endcase
  end

  assign lane_o.carry_o = sum[lane_w];
  assign lane_o.a_msb   = lane_i.a[lane_w-1];
  // Recover the original sign of b
  assign lane_o.b_msb   = lane_i.b[lane_w-1] ^ b_inverted;

endmodule

// ==== verilog/alu_operand_prep.sv ====
////////////////////////////////////////////////////////////
// Operator and vector mode decode shared by all lanes
// Subtract and compares run as a + ~b + 1
// Undefined operator codes fall back to subtract
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_operand_prep (
  input  ex_pkg::alu_op_e                      operator_i,
  input  ex_pkg::vec_mode_e                    vec_mode_i,
  input  logic [ex_pkg::xlen-1:0]              operand_a_i,
  input  logic [ex_pkg::xlen-1:0]              operand_b_i,
  output ex_pkg::lane_in_t [ex_pkg::n_lanes-1:0] lanes_o
);

  import ex_pkg::*;

  lane_func_e         func;
  logic               seed;
  logic [n_lanes-1:0] elem_start;

  // Operator decode, done once for every lane
  always_comb begin
    func = lf_sum;
    seed = 1'b0;
    unique case (operator_i)
      alu_add: seed = 1'b0;
      alu_and: func = lf_and;
      alu_or:  func = lf_or;
      alu_xor: func = lf_xor;
      // Subtract and all compares
      default: seed = 1'b1;
    endcase
  end

  // Lanes that open a new element do not take the lower carry
  always_comb begin
    for (int k = 0; k < n_lanes; k++) begin
      unique case (vec_mode_i)
        vec_byte: elem_start[k] = 1'b1;
        vec_half: elem_start[k] = (k % 2 == 0);
        default:  elem_start[k] = (k == 0);
      endcase
    end
  end

  // Slice operands into lanes
  always_comb begin
    for (int k = 0; k < n_lanes; k++) begin
      lanes_o[k].a          = operand_a_i[k*lane_w +: lane_w];
      // Inverted b plus seed gives the two's complement
      lanes_o[k].b          = seed ? ~operand_b_i[k*lane_w +: lane_w]
                                   :  operand_b_i[k*lane_w +: lane_w];
      lanes_o[k].chain      = ~elem_start[k];
      lanes_o[k].carry_seed = seed;
      lanes_o[k].func       = func;
    end
  end

endmodule

// ==== verilog/alu_result_merge.sv ====
////////////////////////////////////////////////////////////
// Merges lane outputs into the result and comparison flag
// Compares give 0/1 in word mode and element masks in SIMD modes
// Non-compare operators report a comparison flag of 0
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module alu_result_merge (
  input  ex_pkg::alu_op_e                        operator_i,
  input  ex_pkg::vec_mode_e                      vec_mode_i,
  input  ex_pkg::lane_out_t [ex_pkg::n_lanes-1:0] lanes_i,
  output logic [ex_pkg::xlen-1:0]                result_o,
  output logic                                   cmp_o
);

  import ex_pkg::*;

  logic [n_lanes-1:0] lane_zero;
  logic [n_lanes-1:0] lane_ltu;
  logic [n_lanes-1:0] lane_lts;
  // Outcome of the element each lane belongs to
  logic [n_lanes-1:0] lane_hit;
  logic               is_cmp;
  simd_word_u         res;

  assign is_cmp = operator_i inside {alu_eq, alu_ne, alu_lts, alu_ltu, alu_ges, alu_geu};

  // Per lane flags, only meaningful at an element top
  always_comb begin
    for (int k = 0; k < n_lanes; k++) begin
      lane_zero[k] = ~|lanes_i[k].result;
      lane_ltu[k]  = ~lanes_i[k].carry_o;
      // Differing signs decide directly, else the difference sign
      lane_lts[k]  = (lanes_i[k].a_msb != lanes_i[k].b_msb) ? lanes_i[k].a_msb
                                                            : lanes_i[k].result[lane_w-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // Element grouping and compare evaluation
  ////////////////////////////////////////////////////////////
  always_comb begin : elem_eval
    int                 top;
    logic [n_lanes-1:0] members;
    for (int k = 0; k < n_lanes; k++) begin
      members = '0;
      unique case (vec_mode_i)
        vec_byte: begin
          top        = k;
          members[k] = 1'b1;
        end
        vec_half: begin
          top             = k | 1;
          members[k & ~1] = 1'b1;
          members[k | 1]  = 1'b1;
        end
        default: begin
          top     = n_lanes - 1;
          members = '1;
        end
      endcase
      unique case (operator_i)
        alu_eq:  lane_hit[k] =  &(lane_zero | ~members);
        alu_ne:  lane_hit[k] = ~&(lane_zero | ~members);
        alu_lts: lane_hit[k] =  lane_lts[top];
        alu_ltu: lane_hit[k] =  lane_ltu[top];
        alu_ges: lane_hit[k] = ~lane_lts[top];
        alu_geu: lane_hit[k] = ~lane_ltu[top];
        default: lane_hit[k] = 1'b0;
      endcase
    end
  end

  // Result word through the matching view
  always_comb begin
    res.word = '0;
    if (!is_cmp) begin
      for (int k = 0; k < n_lanes; k++) begin
        res.bytes[k] = lanes_i[k].result;
      end
    end else if (vec_mode_i == vec_half) begin
      for (int h = 0; h < 2; h++) begin
        res.half[h] = {(2*lane_w){lane_hit[2*h]}};
      end
    end else if (vec_mode_i == vec_byte) begin
      for (int k = 0; k < n_lanes; k++) begin
        res.bytes[k] = {lane_w{lane_hit[k]}};
      end
    end else begin
      res.word = {{(xlen-1){1'b0}}, lane_hit[0]};
    end
  end

  assign result_o = res.word;
  // All lanes of an element agree, so the AND spans the elements
  assign cmp_o    = &lane_hit;

endmodule

// ==== verilog/simd_alu.sv ====
////////////////////////////////////////////////////////////
// Packed SIMD ALU built from four byte lanes
// Purely combinational, one operation per cycle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module simd_alu (
  input  ex_pkg::alu_op_e         operator_i,
  input  ex_pkg::vec_mode_e       vec_mode_i,
  input  logic [ex_pkg::xlen-1:0] operand_a_i,
  input  logic [ex_pkg::xlen-1:0] operand_b_i,
  output logic [ex_pkg::xlen-1:0] result_o,
  output logic                    cmp_o
);

  import ex_pkg::*;

  lane_in_t  [n_lanes-1:0] lane_in;
  lane_out_t [n_lanes-1:0] lane_out;
  // Carry offered to each lane by its lower neighbour
  logic      [n_lanes-1:0] lane_cin;

  alu_operand_prep u_prep (
    .operator_i  (operator_i),
    .vec_mode_i  (vec_mode_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .lanes_o     (lane_in)
  );

  ////////////////////////////////////////////////////////////
  // Lane array with ripple carry between neighbours
  ////////////////////////////////////////////////////////////
  for (genvar k = 0; k < n_lanes; k++) begin : g_lane
    if (k == 0) begin : g_first
      // Lowest lane always starts an element
      assign lane_cin[k] = 1'b0;
    end else begin : g_chain
      assign lane_cin[k] = lane_out[k-1].carry_o;
    end

    alu_lane u_lane (
      .lane_i  (lane_in[k]),
      .carry_i (lane_cin[k]),
      .lane_o  (lane_out[k])
    );
  end

  alu_result_merge u_merge (
    .operator_i (operator_i),
    .vec_mode_i (vec_mode_i),
    .lanes_i    (lane_out),
    .result_o   (result_o),
    .cmp_o      (cmp_o)
  );

endmodule

// ==== verilog/ex_writeback.sv ====
////////////////////////////////////////////////////////////
// Forwarding port, EX/WB register and stall levels
// The forwarding port and stall levels are combinational
// The EX/WB register holds only the load-store write enable and address
// Ready is forced high while a branch sits in EX
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_writeback (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    alu_en_i,
  input  ex_pkg::wb_ctrl_t        wb_ctrl_i,
  input  logic [ex_pkg::xlen-1:0] alu_result_i,

  input  logic                    csr_access_i,
  input  logic [ex_pkg::xlen-1:0] csr_rdata_i,

  input  logic                    lsu_en_i,
  input  logic [ex_pkg::xlen-1:0] lsu_rdata_i,
  input  logic                    lsu_ready_ex_i,

  input  logic                    branch_in_ex_i,
  input  logic                    wb_ready_i,

  output ex_pkg::wr_port_t        fw_port_o,
  output ex_pkg::wr_port_t        wb_port_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  import ex_pkg::*;

  logic                  lsu_we_q;
  logic [reg_addr_w-1:0] lsu_waddr_q;
  logic                  downstream_ok;

  // ALU write port, CSR read data wins over the ALU
  always_comb begin
    fw_port_o.waddr = wb_ctrl_i.alu_waddr;
    fw_port_o.we    = wb_ctrl_i.alu_we;
    fw_port_o.wdata = csr_access_i ? csr_rdata_i : alu_result_i;
  end

  ////////////////////////////////////////////////////////////
  // Stall control
  ////////////////////////////////////////////////////////////
  assign downstream_ok = lsu_ready_ex_i & wb_ready_i;

  assign ex_valid_o = (alu_en_i | csr_access_i | lsu_en_i) & downstream_ok;
  assign ex_ready_o = downstream_ok | branch_in_ex_i;

  ////////////////////////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_o) begin
      // Accepting edge, wb_ready_i is already part of valid
      lsu_we_q <= wb_ctrl_i.lsu_we;
      if (wb_ctrl_i.lsu_we) begin
        lsu_waddr_q <= wb_ctrl_i.lsu_waddr;
      end
    end else if (wb_ready_i) begin
      // Nothing new while WB drains, flush the slot
      lsu_we_q <= 1'b0;
    end
    // Both low: back-pressure, hold
  end

  // Load data goes through without a register
  assign wb_port_o = '{waddr: lsu_waddr_q, we: lsu_we_q, wdata: lsu_rdata_i};

endmodule

// ==== verilog/ex_stage.sv ====
////////////////////////////////////////////////////////////
// Reduced execute stage: SIMD ALU plus write-back ports
// Branch decision and jump target are combinational
// Load data is not registered here, it comes straight from the LSU
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,

  // Operation from ID
  input  ex_pkg::alu_req_t       alu_req_i,
  input  ex_pkg::wb_ctrl_t       wb_ctrl_i,

  // CSR access
  input  logic                   csr_access_i,
  input  logic [ex_pkg::xlen-1:0] csr_rdata_i,

  // Load-store unit
  input  logic                   lsu_en_i,
  input  logic [ex_pkg::xlen-1:0] lsu_rdata_i,
  input  logic                   lsu_ready_ex_i,

  // Stall inputs
  input  logic                   branch_in_ex_i,
  input  logic                   wb_ready_i,

  // Register file ports
  output ex_pkg::wr_port_t       fw_port_o,
  output ex_pkg::wr_port_t       wb_port_o,

  // Towards IF
  output logic [ex_pkg::xlen-1:0] jump_target_o,
  output logic                   branch_decision_o,

  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  import ex_pkg::*;

  logic [xlen-1:0] alu_result;
  logic            alu_cmp;

  // Branch handling
  assign jump_target_o     = alu_req_i.operand_c;
  assign branch_decision_o = alu_cmp;

  simd_alu u_alu (
    .operator_i  (alu_req_i.operator),
    .vec_mode_i  (alu_req_i.vec_mode),
    .operand_a_i (alu_req_i.operand_a),
    .operand_b_i (alu_req_i.operand_b),
    .result_o    (alu_result),
    .cmp_o       (alu_cmp)
  );

  ex_writeback u_wb (
    .clk            (clk),
    .rst_n          (rst_n),
    .alu_en_i       (alu_req_i.en),
    .wb_ctrl_i      (wb_ctrl_i),
    .alu_result_i   (alu_result),
    .csr_access_i   (csr_access_i),
    .csr_rdata_i    (csr_rdata_i),
    .lsu_en_i       (lsu_en_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .branch_in_ex_i (branch_in_ex_i),
    .wb_ready_i     (wb_ready_i),
    .fw_port_o      (fw_port_o),
    .wb_port_o      (wb_port_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

endmodule

// ==== include/ex_ref_model.svh ====
////////////////////////////////////////////////////////////
// Reference functions for the execute stage testbench
// Include inside a scope that already imports ex_pkg
// Elements are computed independently, no carry crosses them
////////////////////////////////////////////////////////////

`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Element width in bits for a vector mode
function automatic int ref_elem_w(vec_mode_e mode);
  case (mode)
    vec_byte: return 8;
    vec_half: return 16;
    default:  return 32;
  endcase
endfunction

// Compare of one element, x and y zero-extended to 32 bits
function automatic logic ref_elem_hit(alu_op_e op, logic [31:0] x, logic [31:0] y, int ew);
  logic signed [31:0] xs;
  logic signed [31:0] ys;
  // Move the element sign bit to bit 31
  xs = x << (32 - ew);
  ys = y << (32 - ew);
  case (op)
    alu_eq:  return x == y;
    alu_ne:  return x != y;
    alu_lts: return xs < ys;
    alu_ltu: return x < y;
    alu_ges: return xs >= ys;
    alu_geu: return x >= y;
    default: return 1'b0;
  endcase
endfunction

// Expected ALU result word
function automatic simd_word_u ref_alu_result(alu_op_e op, vec_mode_e mode,
                                              logic [31:0] a, logic [31:0] b);
  simd_word_u  r;
  logic [31:0] x;
  logic [31:0] y;
  logic [31:0] m;
  int          ew;
  ew     = ref_elem_w(mode);
  m      = (ew == 32) ? 32'hffff_ffff : ((32'd1 << ew) - 32'd1);
  r.word = '0;
  for (int e = 0; e < 32 / ew; e++) begin
    x = (a >> (e * ew)) & m;
    y = (b >> (e * ew)) & m;
    case (op)
      alu_add: x = x + y;
      alu_sub: x = x - y;
      alu_and: x = x & y;
      alu_or:  x = x | y;
      alu_xor: x = x ^ y;
      // Compares give 0/1 in word mode, masks otherwise
      default: x = !ref_elem_hit(op, x, y, ew) ? 32'd0 : (mode == vec_word) ? 32'd1 : m;
    endcase
    r.word |= (x & m) << (e * ew);
  end
  return r;
endfunction

// Expected comparison outcome, the AND over all elements
function automatic logic ref_alu_cmp(alu_op_e op, vec_mode_e mode,
                                     logic [31:0] a, logic [31:0] b);
  logic [31:0] m;
  logic        hit;
  int          ew;
  ew  = ref_elem_w(mode);
  m   = (ew == 32) ? 32'hffff_ffff : ((32'd1 << ew) - 32'd1);
  hit = 1'b1;
  for (int e = 0; e < 32 / ew; e++) begin
    hit &= ref_elem_hit(op, (a >> (e * ew)) & m, (b >> (e * ew)) & m, ew);
  end
  return hit;
endfunction

// Expected EX/WB state after one rising edge, wdata is left untouched
function automatic wr_port_t ref_wb_next(wr_port_t cur, logic ex_valid, logic wb_ready,
                                         wb_ctrl_t ctrl);
  wr_port_t nxt;
  nxt = cur;
  if (ex_valid) begin
    nxt.we = ctrl.lsu_we;
    if (ctrl.lsu_we) begin
      nxt.waddr = ctrl.lsu_waddr;
    end
  end else if (wb_ready) begin
    nxt.we = 1'b0;
  end
  return nxt;
endfunction

`endif

// ==== sim/tb_ex_stage.sv ====
////////////////////////////////////////////////////////////
// Random testbench for the reduced execute stage
// Inputs change on the falling edge, outputs are sampled 5 ns later
// Only legal operator codes and vector modes are driven
// The EX/WB model steps once per rising edge after reset release
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ex_stage;

  import ex_pkg::*;

  `include "ex_ref_model.svh"

  localparam int n_iter     = 2000;
  localparam int max_cycles = 5000;

  logic            clk;
  logic            rst_n;
  alu_req_t        alu_req;
  wb_ctrl_t        wb_ctrl;
  logic            csr_access;
  logic [xlen-1:0] csr_rdata;
  logic            lsu_en;
  logic [xlen-1:0] lsu_rdata;
  logic            lsu_ready_ex;
  logic            branch_in_ex;
  logic            wb_ready;

  wr_port_t        fw_port;
  wr_port_t        wb_port;
  logic [xlen-1:0] jump_target;
  logic            branch_decision;
  logic            ex_ready;
  logic            ex_valid;

  integer          seed;
  int              word_errs;
  int              flag_errs;
  int              port_errs;
  logic            done;
  // Model of the EX/WB register, wdata unused
  wr_port_t        exp_wb;

  ex_stage dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req),
    .wb_ctrl_i         (wb_ctrl),
    .csr_access_i      (csr_access),
    .csr_rdata_i       (csr_rdata),
    .lsu_en_i          (lsu_en),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .branch_in_ex_i    (branch_in_ex),
    .wb_ready_i        (wb_ready),
    .fw_port_o         (fw_port),
    .wb_port_o         (wb_port),
    .jump_target_o     (jump_target),
    .branch_decision_o (branch_decision),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks, one per result kind
  ////////////////////////////////////////////////////////////
  task automatic check_word(input simd_word_u got, input simd_word_u exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got.word, exp.word);
      word_errs++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      flag_errs++;
    end
  endtask

  task automatic check_port(input wr_port_t got, input wr_port_t exp, input string what);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got waddr %h we %b wdata %h expected waddr %h we %b wdata %h",
               $time, what, got.waddr, got.we, got.wdata, exp.waddr, exp.we, exp.wdata);
      port_errs++;
    end
  endtask

  // Valid rule: some unit busy and both consumers ready
  function automatic logic expect_valid(logic en, logic csr, logic lsu, logic lsu_rdy,
                                        logic wb_rdy);
    return (en | csr | lsu) & lsu_rdy & wb_rdy;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  task automatic drive_random();
    logic [3:0]  op_code;
    logic [31:0] pick;
    logic [31:0] mix;
    op_code = {$random(seed)} % 11;
    alu_req.operator = alu_op_e'(op_code);
    case ({$random(seed)} % 3)
      0:       alu_req.vec_mode = vec_word;
      1:       alu_req.vec_mode = vec_half;
      default: alu_req.vec_mode = vec_byte;
    endcase
    alu_req.en        = $random(seed);
    alu_req.operand_a = $random(seed);
    alu_req.operand_c = $random(seed);
    pick              = {$random(seed)} % 4;
    mix               = $random(seed);
    // Equal and partly equal operands so compares hit both outcomes
    if (pick == 0) begin
      alu_req.operand_b = alu_req.operand_a;
    end else if (pick == 1) begin
      alu_req.operand_b = (alu_req.operand_a & mix) | ($random(seed) & ~mix);
    end else begin
      alu_req.operand_b = $random(seed);
    end
    wb_ctrl.alu_waddr = $random(seed);
    wb_ctrl.alu_we    = $random(seed);
    wb_ctrl.lsu_waddr = $random(seed);
    wb_ctrl.lsu_we    = $random(seed);
    // CSR access kept rare so the ALU result shows on the port
    csr_access   = ({$random(seed)} % 4) == 0;
    csr_rdata    = $random(seed);
    lsu_en       = $random(seed);
    lsu_rdata    = $random(seed);
    lsu_ready_ex = ({$random(seed)} % 4) != 0;
    wb_ready     = ({$random(seed)} % 4) != 0;
    branch_in_ex = ({$random(seed)} % 4) == 0;
  endtask

  // Combinational outputs against the reference functions
  task automatic check_outputs();
    simd_word_u exp_res;
    wr_port_t   exp_fw;
    string      tag;
    tag     = $sformatf("%s %s", alu_req.operator.name(), alu_req.vec_mode.name());
    exp_res = ref_alu_result(alu_req.operator, alu_req.vec_mode,
                             alu_req.operand_a, alu_req.operand_b);
    if (!csr_access) begin
      check_word(fw_port.wdata, exp_res, {tag, " result"});
    end
    exp_fw.waddr = wb_ctrl.alu_waddr;
    exp_fw.we    = wb_ctrl.alu_we;
    exp_fw.wdata = csr_access ? csr_rdata : exp_res.word;
    check_port(fw_port, exp_fw, "forwarding port");
    check_word(jump_target, alu_req.operand_c, "jump target");
    check_flag(branch_decision,
               ref_alu_cmp(alu_req.operator, alu_req.vec_mode,
                           alu_req.operand_a, alu_req.operand_b),
               {tag, " branch decision"});
    check_flag(ex_valid, expect_valid(alu_req.en, csr_access, lsu_en, lsu_ready_ex, wb_ready),
               "ex_valid");
    check_flag(ex_ready, (lsu_ready_ex & wb_ready) | branch_in_ex, "ex_ready");
  endtask

  // Registered port plus the pass-through load data
  task automatic check_wb_port();
    wr_port_t exp;
    exp       = exp_wb;
    exp.wdata = lsu_rdata;
    check_port(wb_port, exp, "EX/WB port");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed         = 16;
    word_errs    = 0;
    flag_errs    = 0;
    port_errs    = 0;
    done         = 1'b0;
    exp_wb       = '0;
    rst_n        = 1'b0;
    alu_req      = '0;
    wb_ctrl      = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    lsu_en       = 1'b0;
    lsu_rdata    = '0;
    lsu_ready_ex = 1'b0;
    branch_in_ex = 1'b0;
    wb_ready     = 1'b0;

    repeat (2) @(posedge clk);
    @(negedge clk);
    // Register must read zero while reset is held
    check_wb_port();
    rst_n = 1'b1;
    // First edge after release sees the idle inputs
    exp_wb = ref_wb_next(exp_wb,
                         expect_valid(alu_req.en, csr_access, lsu_en, lsu_ready_ex, wb_ready),
                         wb_ready, wb_ctrl);

    for (int i = 0; i < n_iter; i++) begin
      @(negedge clk);
      check_wb_port();
      drive_random();
      #5;
      check_outputs();
      check_wb_port();
      exp_wb = ref_wb_next(exp_wb,
                           expect_valid(alu_req.en, csr_access, lsu_en, lsu_ready_ex, wb_ready),
                           wb_ready, wb_ctrl);
    end

    done = 1'b1;
    $display("Errors: result %0d, flag %0d, port %0d", word_errs, flag_errs, port_errs);
    if (word_errs + flag_errs + port_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog on the whole run
  initial begin
    int cycles;
    cycles = 0;
    while (!done && cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    if (!done) begin
      $display("Timeout: the test did not finish within %0d cycles", max_cycles);
      $display("Something failed");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+include
verilog/ex_pkg.sv
verilog/alu_lane.sv
verilog/alu_operand_prep.sv
verilog/alu_result_merge.sv
verilog/simd_alu.sv
verilog/ex_writeback.sv
verilog/ex_stage.sv
sim/tb_ex_stage.sv
